// ==== logic/axis_width_down.sv ====
//////////////////////////////////////////////////
// Stream width down-converter
//////////////////////////////////////////////////
`timescale 1ns/1ps

module axis_width_down
    import axis_word_pkg::*;
#(
    parameter int OUT_BYTES = 4
) (
    input  logic                   clk_ifc,
    input  logic                   rst_n,
    input  logic                   rd_valid,
    input  axis_word_t             rd_word,
    input  logic                   out_tready,
    output logic                   rd_ready,
    output logic                   out_tvalid,
    output logic [OUT_BYTES*8-1:0] out_tdata,
    output logic [OUT_BYTES-1:0]   out_tkeep,
    output logic                   out_tlast
);

    localparam int LANES     = IN_BYTES / OUT_BYTES;
    localparam int LANE_BITS = (LANES > 1) ? $clog2(LANES) : 1;

    axis_word_t           word_q;
    logic                 full_q;
    logic [LANE_BITS-1:0] lane_q;
    // Set where the following lane still holds a kept byte
    logic [LANES-1:0]     more;
    logic                 last_lane;
    logic                 done;
    logic                 take;

    generate
        if (OUT_BYTES < 1 || (IN_BYTES % OUT_BYTES) != 0) begin : g_width_check
            $error("OUT_BYTES must divide the ingress word width");
        end

        // Keep is contiguous from byte 0, so one look ahead finds the end
        for (genvar l = 0; l < LANES; l++) begin : g_more
            if (l < LANES - 1) begin : g_next
                assign more[l] = |word_q.tkeep[(l + 1) * OUT_BYTES +: OUT_BYTES];
            end else begin : g_end
                assign more[l] = 1'b0;
            end
        end
    endgenerate

    assign last_lane = !more[lane_q];

    //////////////////////////////////////////////////
    // Output lane

    assign out_tvalid = full_q;
    assign out_tdata  = word_q.tdata[lane_q * OUT_BYTES * 8 +: OUT_BYTES * 8];
    assign out_tkeep  = word_q.tkeep[lane_q * OUT_BYTES +: OUT_BYTES];
    assign out_tlast  = word_q.tlast && last_lane;

    // Next word is taken as the final lane of the current one leaves
    assign done     = full_q && out_tready && last_lane;
    assign rd_ready = !full_q || done;
    assign take     = rd_valid && rd_ready;

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
            lane_q <= '0;
        end else if (take) begin
            full_q <= 1'b1;
            lane_q <= '0;
        end else if (done) begin
            full_q <= 1'b0;
        end else if (full_q && out_tready) begin
            lane_q <= lane_q + 1'b1;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (take) begin
            word_q <= rd_word;
        end
    end

    a_hold_beat: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata))
    ) else $error("output beat changed under back-pressure");

endmodule

// ==== logic/axis_word_pkg.sv ====
//////////////////////////////////////////////////
// Ingress stream word
//////////////////////////////////////////////////

package axis_word_pkg;

    // Ingress bus geometry
    localparam int IN_BYTES  = 8;
    localparam int IN_BITS   = IN_BYTES * 8;
    localparam int KEEP_BITS = IN_BYTES;

    //////////////////////////////////////////////////
    // One stored beat

    // Layout of a buffer memory entry, 73 bits
    typedef struct packed {
        logic [IN_BITS-1:0]   tdata;
        logic [KEEP_BITS-1:0] tkeep;
        logic                 tlast;
    } axis_word_t;

endpackage

// ==== logic/egress_port_demux.sv ====
//////////////////////////////////////////////////
// Egress port demultiplexer
//////////////////////////////////////////////////
`timescale 1ns/1ps

module egress_port_demux
    import axis_word_pkg::*, egress_port_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 clk_ifc,
    input  logic                 rst_n,
    input  logic                 in_tvalid,
    input  logic [IN_BITS-1:0]   in_tdata,
    input  logic [KEEP_BITS-1:0] in_tkeep,
    input  logic                 in_tlast,
    input  port_id_t             in_tuser,
    output logic                 in_tready,
    output logic [NUM_PORTS-1:0] wr_valid,
    output axis_word_t           wr_word
);

    logic     mid_pkt;
    port_id_t port_q;
    port_id_t cur_port;
    logic     beat;

    // Buffers absorb or drop every beat, so ready stays up once out of reset
    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            in_tready <= 1'b0;
        end else begin
            in_tready <= 1'b1;
        end
    end

    assign beat = in_tvalid && in_tready;

    // First beat routes on tuser, later beats on the latched port
    assign cur_port = mid_pkt ? port_q : in_tuser;

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            mid_pkt <= 1'b0;
            port_q  <= '0;
        end else if (beat) begin
            mid_pkt <= !in_tlast;
            if (!mid_pkt) begin
                port_q <= in_tuser;
            end
        end
    end

    // Port numbers past the last port match no select line
    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_sel
            assign wr_valid[p] = beat && (cur_port == port_id_t'(p));
        end
    endgenerate

    assign wr_word.tdata = in_tdata;
    assign wr_word.tkeep = in_tkeep;
    assign wr_word.tlast = in_tlast;

    a_tuser_stable: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        (beat && mid_pkt) |-> (in_tuser == port_q)
    ) else $error("tuser changed inside a packet");

endmodule

// ==== logic/egress_port_pkg.sv ====
//////////////////////////////////////////////////
// Egress port numbering and widths
//////////////////////////////////////////////////

package egress_port_pkg;

    // Port number carried in tuser
    localparam int PORT_ID_BITS = 4;

    typedef logic [PORT_ID_BITS-1:0] port_id_t;

    //////////////////////////////////////////////////
    // Port classes

    // Bytes per beat on each physical port class
    localparam int BYTES_8B  = 1;
    localparam int BYTES_32B = 4;

    // 8-bit ports are numbered first, 32-bit ports follow them

endpackage

// ==== logic/pkt_drop_buffer.sv ====
//////////////////////////////////////////////////
// Store-and-forward packet buffer with drop
//////////////////////////////////////////////////
`timescale 1ns/1ps

module pkt_drop_buffer
    import axis_word_pkg::*;
#(
    parameter int BUF_WORDS = 64
) (
    input  logic       clk_ifc,
    input  logic       rst_n,
    input  logic       wr_valid,
    input  axis_word_t wr_word,
    input  logic       rd_ready,
    output logic       rd_valid,
    output axis_word_t rd_word,
    output logic       overflow
);

    localparam int ADDR_BITS = $clog2(BUF_WORDS);
    localparam int CNT_BITS  = $clog2(BUF_WORDS + 1);

    axis_word_t           mem [BUF_WORDS];

    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] wr_commit;
    logic [ADDR_BITS-1:0] rd_ptr;

    // Committed words still held, including the one on rd_word
    logic [CNT_BITS-1:0]  cnt_commit;
    // Words of the packet being written
    logic [CNT_BITS-1:0]  cnt_pend;
    logic [CNT_BITS:0]    occ;
    logic [CNT_BITS-1:0]  unfetched;

    logic                 drop_q;
    logic                 full;
    logic                 accept;
    logic                 commit;
    logic                 pop;
    logic                 fetch;

    function automatic logic [ADDR_BITS-1:0] ptr_inc(input logic [ADDR_BITS-1:0] ptr);
        if (ptr == ADDR_BITS'(BUF_WORDS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Write side

    assign occ    = cnt_commit + cnt_pend;
    assign full   = (occ == (CNT_BITS + 1)'(BUF_WORDS));
    assign accept = wr_valid && !drop_q && !full;
    assign commit = accept && wr_word.tlast;

    // Last word of a packet that did not fit
    assign overflow = wr_valid && wr_word.tlast && !accept;

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            wr_commit <= '0;
            cnt_pend  <= '0;
            drop_q    <= 1'b0;
        end else if (wr_valid) begin
            if (accept) begin
                wr_ptr <= ptr_inc(wr_ptr);
                if (wr_word.tlast) begin
                    wr_commit <= ptr_inc(wr_ptr);
                    cnt_pend  <= '0;
                end else begin
                    cnt_pend <= cnt_pend + 1'b1;
                end
            end else begin
                // Rewind to the packet start, swallow the rest up to tlast
                wr_ptr   <= wr_commit;
                cnt_pend <= '0;
                drop_q   <= !wr_word.tlast;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side

    assign pop       = rd_valid && rd_ready;
    assign unfetched = cnt_commit - CNT_BITS'(rd_valid);
    assign fetch     = (unfetched != '0) && (!rd_valid || rd_ready);

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            rd_valid   <= 1'b0;
            cnt_commit <= '0;
        end else begin
            cnt_commit <= cnt_commit + (commit ? cnt_pend + 1'b1 : '0) - CNT_BITS'(pop);
            if (fetch) begin
                rd_ptr   <= ptr_inc(rd_ptr);
                rd_valid <= 1'b1;
            end else if (pop) begin
                rd_valid <= 1'b0;
            end
        end
    end

    // Word storage and output register
    always_ff @(posedge clk_ifc) begin
        if (accept) begin
            mem[wr_ptr] <= wr_word;
        end
        if (fetch) begin
            rd_word <= mem[rd_ptr];
        end
    end

    a_occ_bound: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        occ <= (CNT_BITS + 1)'(BUF_WORDS)
    ) else $error("buffer occupancy above BUF_WORDS");

    a_rd_committed: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        $rose(rd_valid) |-> (cnt_commit != '0)
    ) else $error("rd_valid rose with nothing committed");

endmodule

// ==== logic/router_egress.sv ====
//////////////////////////////////////////////////
// Router egress stage
//////////////////////////////////////////////////
`timescale 1ns/1ps

module router_egress
    import axis_word_pkg::*, egress_port_pkg::*;
#(
    parameter int  NUM_8B_PORTS  = 2,
    parameter int  NUM_32B_PORTS = 2,
    parameter int  BUF_WORDS     = 64,
    localparam int NUM_PORTS     = NUM_8B_PORTS + NUM_32B_PORTS
) (
    input  logic                                      clk_ifc,
    input  logic                                      rst_n,

    // Ingress
    input  logic                                      in_tvalid,
    input  logic [IN_BITS-1:0]                        in_tdata,
    input  logic [KEEP_BITS-1:0]                      in_tkeep,
    input  logic                                      in_tlast,
    input  port_id_t                                  in_tuser,
    output logic                                      in_tready,

    // 8-bit ports
    output logic [NUM_8B_PORTS-1:0]                   out8_tvalid,
    output logic [NUM_8B_PORTS-1:0][BYTES_8B*8-1:0]   out8_tdata,
    output logic [NUM_8B_PORTS-1:0]                   out8_tlast,
    input  logic [NUM_8B_PORTS-1:0]                   out8_tready,

    // 32-bit ports
    output logic [NUM_32B_PORTS-1:0]                  out32_tvalid,
    output logic [NUM_32B_PORTS-1:0][BYTES_32B*8-1:0] out32_tdata,
    output logic [NUM_32B_PORTS-1:0][BYTES_32B-1:0]   out32_tkeep,
    output logic [NUM_32B_PORTS-1:0]                  out32_tlast,
    input  logic [NUM_32B_PORTS-1:0]                  out32_tready,

    output logic [NUM_PORTS-1:0]                      overflow
);

    logic [NUM_PORTS-1:0] wr_valid;
    axis_word_t           wr_word;
    logic [NUM_PORTS-1:0] rd_valid;
    logic [NUM_PORTS-1:0] rd_ready;
    axis_word_t           rd_word [NUM_PORTS];

    egress_port_demux #(
        .NUM_PORTS ( NUM_PORTS )
    ) u_demux (
        .clk_ifc   ( clk_ifc   ),
        .rst_n     ( rst_n     ),
        .in_tvalid ( in_tvalid ),
        .in_tdata  ( in_tdata  ),
        .in_tkeep  ( in_tkeep  ),
        .in_tlast  ( in_tlast  ),
        .in_tuser  ( in_tuser  ),
        .in_tready ( in_tready ),
        .wr_valid  ( wr_valid  ),
        .wr_word   ( wr_word   )
    );

    //////////////////////////////////////////////////
    // Per-port buffers

    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_buf
            pkt_drop_buffer #(
                .BUF_WORDS ( BUF_WORDS )
            ) u_buf (
                .clk_ifc  ( clk_ifc     ),
                .rst_n    ( rst_n       ),
                .wr_valid ( wr_valid[p] ),
                .wr_word  ( wr_word     ),
                .rd_ready ( rd_ready[p] ),
                .rd_valid ( rd_valid[p] ),
                .rd_word  ( rd_word[p]  ),
                .overflow ( overflow[p] )
            );
        end
    endgenerate

    //////////////////////////////////////////////////
    // Width converters

    generate
        for (genvar p = 0; p < NUM_8B_PORTS; p++) begin : g_out8
            axis_width_down #(
                .OUT_BYTES ( BYTES_8B )
            ) u_conv (
                .clk_ifc    ( clk_ifc        ),
                .rst_n      ( rst_n          ),
                .rd_valid   ( rd_valid[p]    ),
                .rd_word    ( rd_word[p]     ),
                .out_tready ( out8_tready[p] ),
                .rd_ready   ( rd_ready[p]    ),
                .out_tvalid ( out8_tvalid[p] ),
                .out_tdata  ( out8_tdata[p]  ),
                .out_tkeep  (                ),
                .out_tlast  ( out8_tlast[p]  )
            );
        end

        // 32-bit ports sit after the 8-bit ones in port numbering
        for (genvar p = 0; p < NUM_32B_PORTS; p++) begin : g_out32
            axis_width_down #(
                .OUT_BYTES ( BYTES_32B )
            ) u_conv (
                .clk_ifc    ( clk_ifc                     ),
                .rst_n      ( rst_n                       ),
                .rd_valid   ( rd_valid[NUM_8B_PORTS + p]  ),
                .rd_word    ( rd_word[NUM_8B_PORTS + p]   ),
                .out_tready ( out32_tready[p]             ),
                .rd_ready   ( rd_ready[NUM_8B_PORTS + p]  ),
                .out_tvalid ( out32_tvalid[p]             ),
                .out_tdata  ( out32_tdata[p]              ),
                .out_tkeep  ( out32_tkeep[p]              ),
                .out_tlast  ( out32_tlast[p]              )
            );
        end
    endgenerate

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the router egress testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module router_egress_tb \
    -f src.f \
    -o router_egress_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/router_egress_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== src.f ====
logic/axis_word_pkg.sv
logic/egress_port_pkg.sv
logic/egress_port_demux.sv
logic/pkt_drop_buffer.sv
logic/axis_width_down.sv
logic/router_egress.sv
testbench/tb_clock_gen.sv
testbench/router_egress_tb.sv

// ==== testbench/router_egress_tb.sv ====
//////////////////////////////////////////////////
// Router egress testbench
//////////////////////////////////////////////////
`timescale 1ns/1ps

module router_egress_tb
    import axis_word_pkg::*, egress_port_pkg::*;
();

    // Mirrors the DUT defaults
    localparam int N8        = 2;
    localparam int N32       = 2;
    localparam int NUM_PORTS = N8 + N32;
    localparam int BUF_WORDS = 64;

    localparam int MAX_LEN         = 200;
    localparam int MAX_PER_PORT    = 64;
    localparam int DRAIN_CYCLES    = 4000;
    localparam int SETTLE_CYCLES   = 20;
    // Upper bound on bytes sent over all tests, tripled for back-pressure
    localparam int TOTAL_PKTS      = 70;
    localparam int WATCHDOG_CYCLES = 3 * TOTAL_PKTS * MAX_LEN + 2000;

    logic                          clk_ifc;
    logic                          rst_n;
    logic                          in_tvalid;
    logic [IN_BITS-1:0]            in_tdata;
    logic [KEEP_BITS-1:0]          in_tkeep;
    logic                          in_tlast;
    port_id_t                      in_tuser;
    logic                          in_tready;
    logic [N8-1:0]                 out8_tvalid;
    logic [N8-1:0][BYTES_8B*8-1:0] out8_tdata;
    logic [N8-1:0]                 out8_tlast;
    logic [N8-1:0]                 out8_tready;
    logic [N32-1:0]                out32_tvalid;
    logic [N32-1:0][BYTES_32B*8-1:0] out32_tdata;
    logic [N32-1:0][BYTES_32B-1:0] out32_tkeep;
    logic [N32-1:0]                out32_tlast;
    logic [N32-1:0]                out32_tready;
    logic [NUM_PORTS-1:0]          overflow;

    // Reference and received packet lengths per port
    int exp_len [NUM_PORTS][MAX_PER_PORT];
    int exp_cnt [NUM_PORTS];
    int rx_len  [NUM_PORTS][MAX_PER_PORT];
    int rx_cnt  [NUM_PORTS];
    int rx_pos  [NUM_PORTS];
    int chk_idx [NUM_PORTS];
    int ovf_cnt [NUM_PORTS];
    logic [BYTES_32B-1:0] last_keep [N32];

    int          errors;
    logic [31:0] lfsr_state;
    bit          bp_on;

    tb_clock_gen #(
        .PERIOD_NS    ( 100 ),
        .RESET_CYCLES ( 5   )
    ) u_clk (
        .clk_ifc ( clk_ifc ),
        .rst_n   ( rst_n   )
    );

    router_egress UUT (
        .clk_ifc      ( clk_ifc      ),
        .rst_n        ( rst_n        ),
        .in_tvalid    ( in_tvalid    ),
        .in_tdata     ( in_tdata     ),
        .in_tkeep     ( in_tkeep     ),
        .in_tlast     ( in_tlast     ),
        .in_tuser     ( in_tuser     ),
        .in_tready    ( in_tready    ),
        .out8_tvalid  ( out8_tvalid  ),
        .out8_tdata   ( out8_tdata   ),
        .out8_tlast   ( out8_tlast   ),
        .out8_tready  ( out8_tready  ),
        .out32_tvalid ( out32_tvalid ),
        .out32_tdata  ( out32_tdata  ),
        .out32_tkeep  ( out32_tkeep  ),
        .out32_tlast  ( out32_tlast  ),
        .out32_tready ( out32_tready ),
        .overflow     ( overflow     )
    );

    //////////////////////////////////////////////////
    // Helpers

    function automatic void report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int next_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            val = (val << 1) | int'(lfsr_state[0]);
        end
        return val;
    endfunction

    function automatic int rand_len();
        return 8 + next_bits(8) % (MAX_LEN - 7);
    endfunction

    function automatic void expect_packet(input int port, input int len);
        exp_len[port][exp_cnt[port]] = len;
        exp_cnt[port]++;
    endfunction

    // Byte i of every packet carries i mod 256
    function automatic void take_byte(input int p, input logic [7:0] b);
        if (b !== 8'(rx_pos[p])) begin
            report_error($sformatf("port %0d byte %0d is %02h, expected %02h",
                                   p, rx_pos[p], b, 8'(rx_pos[p])));
        end
        rx_pos[p]++;
    endfunction

    function automatic void close_packet(input int p);
        if (rx_cnt[p] < MAX_PER_PORT) begin
            rx_len[p][rx_cnt[p]] = rx_pos[p];
        end
        rx_cnt[p]++;
        rx_pos[p] = 0;
    endfunction

    //////////////////////////////////////////////////
    // Output monitors

    always @(posedge clk_ifc) begin : monitor
        logic [BYTES_32B-1:0] keep;
        if (rst_n) begin
            for (int p = 0; p < N8; p++) begin
                if (out8_tvalid[p] && out8_tready[p]) begin
                    take_byte(p, out8_tdata[p]);
                    if (out8_tlast[p]) begin
                        close_packet(p);
                    end
                end
            end
            for (int q = 0; q < N32; q++) begin
                if (out32_tvalid[q] && out32_tready[q]) begin
                    keep = out32_tkeep[q];
                    // Kept bytes start at lane byte 0, full lanes before the last
                    if (keep == '0 || (keep & (keep + 1'b1)) != '0 ||
                        (!out32_tlast[q] && keep != '1)) begin
                        report_error($sformatf("port %0d tkeep is %b", N8 + q, keep));
                    end
                    for (int b = 0; b < BYTES_32B; b++) begin
                        if (keep[b]) begin
                            take_byte(N8 + q, out32_tdata[q][b*8 +: 8]);
                        end
                    end
                    if (out32_tlast[q]) begin
                        last_keep[q] = keep;
                        close_packet(N8 + q);
                    end
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (overflow[p]) begin
                    ovf_cnt[p]++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus and checking tasks

    task automatic send_packet(input int port, input int len);
        int nwords;
        int idx;
        nwords = (len + IN_BYTES - 1) / IN_BYTES;
        for (int w = 0; w < nwords; w++) begin
            @(negedge clk_ifc);
            in_tvalid = 1'b1;
            in_tuser  = port_id_t'(port);
            in_tlast  = (w == nwords - 1);
            for (int b = 0; b < IN_BYTES; b++) begin
                idx = w * IN_BYTES + b;
                in_tdata[b*8 +: 8] = (idx < len) ? 8'(idx) : 8'h00;
                in_tkeep[b]        = (idx < len);
            end
            do @(posedge clk_ifc); while (!in_tready);
        end
        @(negedge clk_ifc);
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        in_tkeep  = '0;
    endtask

    task automatic check_delivery();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rx_cnt[p] != exp_cnt[p]) begin
                report_error($sformatf("port %0d delivered %0d packets, expected %0d",
                                       p, rx_cnt[p], exp_cnt[p]));
            end
            for (int i = chk_idx[p]; i < exp_cnt[p] && i < rx_cnt[p]; i++) begin
                if (rx_len[p][i] != exp_len[p][i]) begin
                    report_error($sformatf("port %0d packet %0d has %0d bytes, expected %0d",
                                           p, i, rx_len[p][i], exp_len[p][i]));
                end
            end
            chk_idx[p] = exp_cnt[p];
        end
    endtask

    task automatic wait_drain();
        int  n;
        bit  done;
        n    = 0;
        done = 1'b0;
        while (!done && n < DRAIN_CYCLES) begin
            @(negedge clk_ifc);
            n++;
            done = 1'b1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rx_cnt[p] < exp_cnt[p]) begin
                    done = 1'b0;
                end
            end
        end
        if (!done) begin
            errors++;
            $display("timeout: expected packets still missing after %0d cycles", DRAIN_CYCLES);
        end
        repeat (SETTLE_CYCLES) @(negedge clk_ifc);
        check_delivery();
    endtask

    task automatic drive_random_ready();
        int r;
        while (bp_on) begin
            @(negedge clk_ifc);
            r = next_bits(N8 + N32);
            out8_tready  = r[N8-1:0];
            out32_tready = r[N8 + N32 - 1:N8];
        end
        out8_tready  = '1;
        out32_tready = '1;
    endtask

    //////////////////////////////////////////////////
    // Tests

    task automatic test_reset_state();
        @(negedge clk_ifc);
        if (in_tready !== 1'b0) begin
            report_error("in_tready is 1 during reset, expected 0");
        end
        wait (rst_n === 1'b1);
        @(posedge clk_ifc);
        @(negedge clk_ifc);
        if (in_tready !== 1'b1) begin
            report_error($sformatf("in_tready is %b after reset, expected 1", in_tready));
        end
        if (out8_tvalid !== '0 || out32_tvalid !== '0) begin
            report_error($sformatf("tvalid is %b/%b after reset, expected 0",
                                   out8_tvalid, out32_tvalid));
        end
        if (overflow !== '0) begin
            report_error($sformatf("overflow is %b after reset, expected 0", overflow));
        end
    endtask

    task automatic test_routing();
        int len;
        for (int k = 0; k < 20; k++) begin
            len = rand_len();
            send_packet(k % NUM_PORTS, len);
            expect_packet(k % NUM_PORTS, len);
            wait_drain();
        end
    endtask

    task automatic test_width_conversion();
        int len;
        int port;
        for (int k = 0; k < 6; k++) begin
            port = N8 + (k % N32);
            len  = rand_len();
            if (len % BYTES_32B == 0) begin
                len = (len < MAX_LEN) ? len + 1 : len - 1;
            end
            send_packet(port, len);
            expect_packet(port, len);
            wait_drain();
            if (last_keep[port - N8] != BYTES_32B'((1 << (len % BYTES_32B)) - 1)) begin
                report_error($sformatf("port %0d last tkeep is %b for %0d bytes",
                                       port, last_keep[port - N8], len));
            end
        end
    endtask

    task automatic test_backpressure();
        int lens [6 * NUM_PORTS];
        int ovf_start;
        ovf_start = ovf_cnt[0] + ovf_cnt[1] + ovf_cnt[2] + ovf_cnt[3];
        for (int i = 0; i < 6 * NUM_PORTS; i++) begin
            lens[i] = rand_len();
        end
        bp_on = 1'b1;
        fork
            drive_random_ready();
            begin
                for (int r = 0; r < 6; r++) begin
                    for (int p = 0; p < NUM_PORTS; p++) begin
                        send_packet(p, lens[r * NUM_PORTS + p]);
                        expect_packet(p, lens[r * NUM_PORTS + p]);
                    end
                    wait_drain();
                end
                @(posedge clk_ifc);
                bp_on = 1'b0;
            end
        join
        if (ovf_cnt[0] + ovf_cnt[1] + ovf_cnt[2] + ovf_cnt[3] != ovf_start) begin
            report_error("overflow pulsed under back-pressure, expected none");
        end
    endtask

    task automatic test_drop_recovery();
        int words [7] = '{20, 20, 20, 10, 4, 2, 3};
        int committed;
        int dropped;
        int ovf_start;
        committed = 0;
        dropped   = 0;
        ovf_start = ovf_cnt[0];
        out8_tready[0] = 1'b0;
        // Port 0 never drains here, so kept words stay committed
        for (int i = 0; i < 7; i++) begin
            send_packet(0, words[i] * IN_BYTES - 2);
            if (words[i] <= BUF_WORDS - committed) begin
                committed += words[i];
                expect_packet(0, words[i] * IN_BYTES - 2);
            end else begin
                dropped++;
            end
        end
        repeat (SETTLE_CYCLES) @(negedge clk_ifc);
        if (ovf_cnt[0] - ovf_start != dropped) begin
            report_error($sformatf("port 0 overflow pulsed %0d times, expected %0d",
                                   ovf_cnt[0] - ovf_start, dropped));
        end
        out8_tready[0] = 1'b1;
        wait_drain();
        // An 8-bit port drains far slower than ingress fills, so each packet is awaited
        for (int i = 0; i < 3; i++) begin
            send_packet(0, MAX_LEN);
            expect_packet(0, MAX_LEN);
            wait_drain();
        end
    endtask

    task automatic test_invalid_port();
        int len;
        send_packet(12, 64);
        for (int p = 0; p < NUM_PORTS; p++) begin
            len = rand_len();
            send_packet(p, len);
            expect_packet(p, len);
        end
        wait_drain();
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin : main
        int total;
        in_tvalid    = 1'b0;
        in_tdata     = '0;
        in_tkeep     = '0;
        in_tlast     = 1'b0;
        in_tuser     = '0;
        out8_tready  = '1;
        out32_tready = '1;
        lfsr_state   = 32'h1ce0049b;
        errors       = 0;
        bp_on        = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_cnt[p] = 0;
            rx_cnt[p]  = 0;
            rx_pos[p]  = 0;
            chk_idx[p] = 0;
            ovf_cnt[p] = 0;
        end

        test_reset_state();
        test_routing();
        test_width_conversion();
        test_backpressure();
        test_drop_recovery();
        test_invalid_port();

        total = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            total += rx_cnt[p];
        end
        $display("packets received %0d, overflow pulses %0d, errors %0d",
                 total, ovf_cnt[0] + ovf_cnt[1] + ovf_cnt[2] + ovf_cnt[3], errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_ifc);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock and reset
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_ifc,
    output logic rst_n
);

    initial begin
        clk_ifc = 1'b0;
        forever #(PERIOD_NS / 2) clk_ifc = ~clk_ifc;
    end

    // Reset is released on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_ifc);
        @(negedge clk_ifc);
        rst_n = 1'b1;
    end

endmodule
